//--- Bender.yml
package:
  name: servo_frontend

sources:
  - files:
      - hw/servo_pkg.sv
      - hw/iir_first_order.sv
      - hw/diff_logger.sv
      - hw/servo_frontend.sv
  - target: simulation
    files:
      - verification/servo_frontend_checker.sv
      - verification/tb_servo_frontend.sv

//--- hw/diff_logger.sv
//////////////////////////////////////////////////////////////////////
// Combining stage of the two filter paths
// Registers chan0 - chan1 and streams four-word log frames to the
// host pipe: counter, chan0, chan1, diff (top log_width bits each)
// Writes stall while pipe_full is high, nothing is dropped
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module diff_logger
	import servo_pkg::*;
(
	input  logic      clk1,
	input  logic      rst,
	input  signal_t   chan0,      // Filtered channel 0
	input  signal_t   chan1,      // Filtered channel 1
	input  logic      pipe_full,  // Host pipe cannot take a word
	output signal_t   diff,       // Registered chan0 - chan1
	output logic      pipe_write, // One word written this cycle
	output log_word_t pipe_data   // Word being written
);

	//////////////////////////////////////////////////////////////////////
	// Signals

	log_word_t sample_cnt; // Free running since reset
	word_idx_t word_idx;   // Next frame word to write
	logic      log_en;     // Logger armed, low through reset
	logic      capture;    // Word 0 goes out, latch the rest

	// Frame words held from the capture cycle
	log_word_t word_chan0;
	log_word_t word_chan1;
	log_word_t word_diff;

	//////////////////////////////////////////////////////////////////////
	// Channel difference

	always_ff @(posedge clk1) begin
		if (rst)
			diff <= '0;
		else
			diff <= chan0 - chan1; // Wraps at signal_width
	end

	//////////////////////////////////////////////////////////////////////
	// Sample counter

	always_ff @(posedge clk1) begin
		if (rst)
			sample_cnt <= '0; // Reads zero first cycle out of reset
		else
			sample_cnt <= sample_cnt + 1'b1;
	end

	//////////////////////////////////////////////////////////////////////
	// Write control

	// Armed one cycle after rst drops
	always_ff @(posedge clk1) begin
		if (rst)
			log_en <= 1'b0;
		else
			log_en <= 1'b1;
	end

	assign pipe_write = log_en & ~pipe_full;      // Never while full
	assign capture    = pipe_write & (word_idx == '0);

	// Frame pointer, holds its place under back-pressure
	always_ff @(posedge clk1) begin
		if (rst) begin
			word_idx <= '0;
		end else if (pipe_write) begin
			if (word_idx == word_idx_t'(log_words - 1))
				word_idx <= '0; // Frame done, next word 0 may follow
			else
				word_idx <= word_idx + 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Frame capture

	// Top log_width bits of each signal at the capture cycle
	always_ff @(posedge clk1) begin
		if (capture) begin
			word_chan0 <= chan0[signal_width-1 -: log_width];
			word_chan1 <= chan1[signal_width-1 -: log_width];
			word_diff  <= diff[signal_width-1 -: log_width];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Output word select

	always_comb begin
		case (word_idx)
			2'd0:    pipe_data = sample_cnt; // Live counter on capture
			2'd1:    pipe_data = word_chan0;
			2'd2:    pipe_data = word_chan1;
			default: pipe_data = word_diff;
		endcase
	end

	// Word 0 is never latched, the counter is read as it stands
	// Words 1 to 3 come from the registers above, so a stall of any
	// length leaves them untouched until written

endmodule

//--- hw/iir_first_order.sv
//////////////////////////////////////////////////////////////////////
// First-order IIR low-pass for one ADC channel
// y[n+1] = (b0*x[n] + b1*x[n-1] + a1*y[n]) >>> coef_frac, clamped
// With on low the scaled sample passes straight through
// One cycle from sample to filtered
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module iir_first_order
	import servo_pkg::*;
(
	input  logic        clk1,
	input  logic        rst,
	input  logic        on,       // Filter enable, low means bypass
	input  coef_t       a1,       // Feedback coefficient
	input  coef_t       b0,       // Current input coefficient
	input  coef_t       b1,       // Previous input coefficient
	input  adc_sample_t sample,   // Raw ADC word, new every cycle
	output signal_t     filtered  // Registered result
);

	//////////////////////////////////////////////////////////////////////
	// Signals

	signal_t x_scaled; // Sample moved into the signal domain
	signal_t x_hist;   // Previous scaled input
	signal_t y_hist;   // Previous filter output

	// Products are coef_width + signal_width wide
	logic signed [coef_width+signal_width-1:0] prod_b0;
	logic signed [coef_width+signal_width-1:0] prod_b1;
	logic signed [coef_width+signal_width-1:0] prod_a1;

	// Two guard bits cover the sum of three products
	logic signed [coef_width+signal_width+1:0] acc;
	logic signed [coef_width+signal_width+1:0] acc_shifted;

	logic    sat_hi;   // Result above signal_max
	logic    sat_lo;   // Result below signal_min
	signal_t y_next;   // Clamped next output

	//////////////////////////////////////////////////////////////////////
	// Input scaling

	// Raw word lands in the top adc_width bits
	assign x_scaled = {sample, {(signal_width-adc_width){1'b0}}};

	//////////////////////////////////////////////////////////////////////
	// Multiply and accumulate

	always_comb begin
		prod_b0 = b0 * x_scaled; // Signed, sign extended to product width
		prod_b1 = b1 * x_hist;
		prod_a1 = a1 * y_hist;

		acc = prod_b0 + prod_b1 + prod_a1;

		// Drop the coefficient fraction
		acc_shifted = acc >>> coef_frac;
	end

	//////////////////////////////////////////////////////////////////////
	// Saturation

	assign sat_hi = (acc_shifted > signal_max);
	assign sat_lo = (acc_shifted < signal_min);

	always_comb begin
		if (sat_hi)
			y_next = signal_max; // Clip positive
		else if (sat_lo)
			y_next = signal_min; // Clip negative
		else
			y_next = signal_t'(acc_shifted); // In range, keep low bits
	end

	//////////////////////////////////////////////////////////////////////
	// Output and history registers

	always_ff @(posedge clk1) begin
		if (rst) begin
			filtered <= '0;
			x_hist   <= '0;
			y_hist   <= '0;
		end else if (!on) begin
			// Bypass, history restarts from zero
			filtered <= x_scaled;
			x_hist   <= '0;
			y_hist   <= '0;
		end else begin
			filtered <= y_next;
			x_hist   <= x_scaled; // x[n-1] for next cycle
			y_hist   <= y_next;   // y[n] for next cycle
		end
	end

	// Note that y_hist tracks filtered only while on is high
	// Right after enabling, the first result sees zero history

endmodule

//--- hw/servo_frontend.sv
//////////////////////////////////////////////////////////////////////
// Analog input path and slow logger of the laser servo board
// Two ADC channels, each low-pass filtered, then a stage that forms
// their difference and streams log frames to the host pipe
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module servo_frontend
	import servo_pkg::*;
(
	input  logic        clk1,
	input  logic        rst,

	// ADC samples, one per cycle
	input  adc_sample_t adc0_raw,
	input  adc_sample_t adc1_raw,

	// Filter settings, static levels from the host side
	input  logic        filt_on0,
	input  logic        filt_on1,
	input  coef_t       a1_0,
	input  coef_t       b0_0,
	input  coef_t       b1_0,
	input  coef_t       a1_1,
	input  coef_t       b0_1,
	input  coef_t       b1_1,

	// Host pipe
	input  logic        pipe_full,

	output signal_t     adc0_filt,  // Filtered channel 0
	output signal_t     adc1_filt,  // Filtered channel 1
	output signal_t     adc_diff,   // adc0_filt - adc1_filt, 1 cycle later
	output logic        pipe_write, // Log word strobe
	output log_word_t   pipe_data   // Log word
);

	//////////////////////////////////////////////////////////////////////
	// Channel filters

	// Channel 0
	iir_first_order u_iir0 (
		.clk1     (clk1),
		.rst      (rst),
		.on       (filt_on0),
		.a1       (a1_0),
		.b0       (b0_0),
		.b1       (b1_0),
		.sample   (adc0_raw),
		.filtered (adc0_filt)
	);

	// Channel 1
	iir_first_order u_iir1 (
		.clk1     (clk1),
		.rst      (rst),
		.on       (filt_on1),
		.a1       (a1_1),
		.b0       (b0_1),
		.b1       (b1_1),
		.sample   (adc1_raw),
		.filtered (adc1_filt)
	);

	//////////////////////////////////////////////////////////////////////
	// Difference and slow logger

	diff_logger u_logger (
		.clk1       (clk1),
		.rst        (rst),
		.chan0      (adc0_filt),
		.chan1      (adc1_filt),
		.pipe_full  (pipe_full),
		.diff       (adc_diff),
		.pipe_write (pipe_write),
		.pipe_data  (pipe_data)
	);

endmodule

//--- hw/servo_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared widths, fixed-point formats and log frame layout for the
// servo analog front end
// Modules pull these in with a wildcard import in their header
//////////////////////////////////////////////////////////////////////

package servo_pkg;

	//////////////////////////////////////////////////////////////////////
	// Data path widths

	localparam int adc_width    = 16; // Raw LTC2195 sample
	localparam int signal_width = 24; // Filtered signal and difference
	localparam int coef_width   = 18; // Signed filter coefficient
	localparam int coef_frac    = 16; // Fractional bits of a coefficient

	//////////////////////////////////////////////////////////////////////
	// Slow logger frame

	localparam int log_width = 16; // One pipe word, also the counter width
	localparam int log_words = 4;  // Counter, chan0, chan1, diff

	//////////////////////////////////////////////////////////////////////
	// Types

	typedef logic signed [adc_width-1:0]    adc_sample_t;
	typedef logic signed [signal_width-1:0] signal_t;
	typedef logic signed [coef_width-1:0]   coef_t;
	typedef logic        [log_width-1:0]    log_word_t;

	// Position inside a log frame
	typedef logic [$clog2(log_words)-1:0] word_idx_t;

	// Clamp limits of the filter output
	localparam signal_t signal_max = {1'b0, {(signal_width-1){1'b1}}};
	localparam signal_t signal_min = {1'b1, {(signal_width-1){1'b0}}};

endpackage

//--- sim.f
hw/servo_pkg.sv
hw/iir_first_order.sv
hw/diff_logger.sv
hw/servo_frontend.sv
verification/servo_frontend_checker.sv
verification/tb_servo_frontend.sv

//--- verification/servo_frontend_checker.sv
//////////////////////////////////////////////////////////////////////
// Concurrent checks on the servo front end ports
// Bound into every servo_frontend instance as u_checker
// Keeps a small reference model, a cycle count and a frame word count
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module servo_frontend_checker
	import servo_pkg::*;
(
	input logic        clk1,
	input logic        rst,
	input adc_sample_t adc0_raw,
	input adc_sample_t adc1_raw,
	input logic        filt_on0,
	input logic        filt_on1,
	input coef_t       a1_0,
	input coef_t       b0_0,
	input coef_t       b1_0,
	input coef_t       a1_1,
	input coef_t       b0_1,
	input coef_t       b1_1,
	input logic        pipe_full,
	input signal_t     adc0_filt,
	input signal_t     adc1_filt,
	input signal_t     adc_diff,
	input logic        pipe_write,
	input log_word_t   pipe_data
);

	int fail_count = 0; // Read by the testbench at the end

	signal_t   x_prev0;   // Previous scaled input of channel 0
	signal_t   x_prev1;
	signal_t   x_hist0;   // Expected DUT history, zero after bypass or reset
	signal_t   x_hist1;
	signal_t   y_hist0;
	signal_t   y_hist1;
	signal_t   exp_filt0; // Expected filter outputs
	signal_t   exp_filt1;
	logic      on_prev0;  // Filter ran last cycle
	logic      on_prev1;
	signal_t   exp_diff;
	logic      armed;     // Expected outputs valid, low through reset
	logic      rst_q;     // rst one cycle ago
	log_word_t cycle_cnt; // Cycles since end of reset
	word_idx_t word_cnt;  // Position in the current frame
	log_word_t held [1:log_words-1]; // Words 1 to 3 from the capture cycle

	// Raw sample moved into the signal domain so its top bits equal the sample
	function automatic signal_t scale(input adc_sample_t raw);
		return {raw, {(signal_width-adc_width){1'b0}}};
	endfunction

	// One step of the filter rule followed by the clamp
	function automatic signal_t filter_step(input coef_t b0, input coef_t b1, input coef_t a1,
		input signal_t x, input signal_t x_prev, input signal_t y_prev);
		longint sum;
		sum = longint'(b0) * longint'(x) + longint'(b1) * longint'(x_prev)
			+ longint'(a1) * longint'(y_prev);
		sum = sum >>> coef_frac;
		if (sum > longint'(signal_max))
			return signal_max;
		else if (sum < longint'(signal_min))
			return signal_min;
		else
			return signal_t'(sum);
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Reference model

	// History clears while the filter is off or in reset
	assign x_hist0 = on_prev0 ? x_prev0 : '0;
	assign x_hist1 = on_prev1 ? x_prev1 : '0;
	assign y_hist0 = on_prev0 ? adc0_filt : '0;
	assign y_hist1 = on_prev1 ? adc1_filt : '0;

	always_ff @(posedge clk1) begin
		rst_q     <= rst;
		x_prev0   <= scale(adc0_raw);
		x_prev1   <= scale(adc1_raw);
		exp_filt0 <= filt_on0
			? filter_step(b0_0, b1_0, a1_0, scale(adc0_raw), x_hist0, y_hist0)
			: scale(adc0_raw);
		exp_filt1 <= filt_on1
			? filter_step(b0_1, b1_1, a1_1, scale(adc1_raw), x_hist1, y_hist1)
			: scale(adc1_raw);
		exp_diff  <= adc0_filt - adc1_filt; // Wraps at signal_width
		if (rst) begin
			on_prev0  <= 1'b0;
			on_prev1  <= 1'b0;
			armed     <= 1'b0;
			cycle_cnt <= '0;
			word_cnt  <= '0;
		end else begin
			on_prev0  <= filt_on0;
			on_prev1  <= filt_on1;
			armed     <= 1'b1;
			cycle_cnt <= cycle_cnt + 1'b1;
			if (pipe_write)
				word_cnt <= word_cnt + 1'b1; // Wraps after word 3
		end
		// Capture cycle latches the rest of the frame
		if (!rst && pipe_write && word_cnt == '0) begin
			held[1] <= adc0_filt[signal_width-1 -: log_width];
			held[2] <= adc1_filt[signal_width-1 -: log_width];
			held[3] <= adc_diff[signal_width-1 -: log_width];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Assertions

	a_filt0: assert property (@(posedge clk1) armed |-> adc0_filt == exp_filt0)
		else begin
			fail_count++;
			$error("MISMATCH time %0t adc0_filt expected %0h actual %0h",
				$time, $sampled(exp_filt0), $sampled(adc0_filt));
		end

	a_filt1: assert property (@(posedge clk1) armed |-> adc1_filt == exp_filt1)
		else begin
			fail_count++;
			$error("MISMATCH time %0t adc1_filt expected %0h actual %0h",
				$time, $sampled(exp_filt1), $sampled(adc1_filt));
		end

	a_diff: assert property (@(posedge clk1) armed |-> adc_diff == exp_diff)
		else begin
			fail_count++;
			$error("MISMATCH time %0t adc_diff expected %0h actual %0h",
				$time, $sampled(exp_diff), $sampled(adc_diff));
		end

	a_no_write_full: assert property (@(posedge clk1) pipe_full |-> !pipe_write)
		else begin
			fail_count++;
			$error("pipe_write was high while pipe_full was high at %0t", $time);
		end

	a_no_write_reset: assert property (@(posedge clk1) rst && rst_q |-> !pipe_write)
		else begin
			fail_count++;
			$error("pipe_write was high during reset at %0t", $time);
		end

	// Word 0 carries the live counter
	a_word0: assert property (@(posedge clk1)
		pipe_write && word_cnt == '0 |-> pipe_data == cycle_cnt)
		else begin
			fail_count++;
			$error("MISMATCH time %0t pipe_data expected %0h actual %0h",
				$time, $sampled(cycle_cnt), $sampled(pipe_data));
		end

	a_word_n: assert property (@(posedge clk1)
		pipe_write && word_cnt != '0 |-> pipe_data == held[word_cnt])
		else begin
			fail_count++;
			$error("MISMATCH time %0t pipe_data expected %0h actual %0h",
				$time, $sampled(held[word_cnt]), $sampled(pipe_data));
		end

endmodule

bind servo_frontend servo_frontend_checker u_checker (.*);

//--- verification/tb_servo_frontend.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the servo analog front end
// Runs bypass, settling, saturation and back-pressure phases
// The bound checker does the checking, this module counts the results
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_servo_frontend
	import servo_pkg::*;
();

	logic        clk1;
	logic        rst;
	adc_sample_t adc0_raw;
	adc_sample_t adc1_raw;
	logic        filt_on0;
	logic        filt_on1;
	coef_t       a1_0;
	coef_t       b0_0;
	coef_t       b1_0;
	coef_t       a1_1;
	coef_t       b0_1;
	coef_t       b1_1;
	logic        pipe_full;
	signal_t     adc0_filt;
	signal_t     adc1_filt;
	signal_t     adc_diff;
	logic        pipe_write;
	log_word_t   pipe_data;

	int   seed;          // $random state
	int   writes = 0;    // Words seen on the pipe
	int   timeouts = 0;
	int   run_left = 0;  // Cycles left in the current pipe_full run
	int   total;
	logic extreme;       // Full scale samples only
	logic stall_on;      // Random back-pressure

	servo_frontend u_dut (.*);

	initial begin
		clk1 = 1'b0;
		forever #10 clk1 = ~clk1; // 20 ns period
	end

	// Count pipe words
	always @(posedge clk1) begin
		if (pipe_write === 1'b1)
			writes <= writes + 1;
	end

	// New samples every cycle, pipe_full in runs of 1 to 8 cycles
	always @(posedge clk1) begin
		if (extreme) begin
			adc0_raw <= ({$random(seed)} % 2) ? 16'sh7FFF : 16'sh8000;
			adc1_raw <= ({$random(seed)} % 2) ? 16'sh7FFF : 16'sh8000;
		end else begin
			adc0_raw <= $random(seed);
			adc1_raw <= $random(seed);
		end
		if (!stall_on) begin
			pipe_full <= 1'b0;
		end else if (run_left == 0) begin
			pipe_full <= ~pipe_full;
			run_left  <= {$random(seed)} % 8;
		end else begin
			run_left <= run_left - 1;
		end
	end

	// Wait for a number of pipe words, bounded by a cycle limit
	task automatic wait_words(input int count, input int limit);
		int target;
		int cycles;
		target = writes + count;
		cycles = 0;
		while (writes < target && cycles < limit) begin
			@(posedge clk1);
			cycles++;
		end
		if (writes < target) begin
			timeouts++;
			$display("Timeout at %0t: only %0d of %0d pipe words arrived", $time,
				count - (target - writes), count);
		end
	endtask

	initial begin
		seed      = 32'h87456168;
		rst       = 1'b1;
		adc0_raw  = '0;
		adc1_raw  = '0;
		filt_on0  = 1'b0;
		filt_on1  = 1'b0;
		a1_0      = '0;
		b0_0      = '0;
		b1_0      = '0;
		a1_1      = '0;
		b0_1      = '0;
		b1_1      = '0;
		pipe_full = 1'b0;
		extreme   = 1'b0;
		stall_on  = 1'b0;
		repeat (8) @(posedge clk1);
		rst <= 1'b0;

		// Phase 1, both channels in bypass
		wait_words(8, 200);

		// Phase 2, unity gain low-pass, 0.75 and 0.5 pole
		@(posedge clk1);
		filt_on0 <= 1'b1;
		filt_on1 <= 1'b1;
		a1_0     <= 18'sd49152;
		b0_0     <= 18'sd8192;
		b1_0     <= 18'sd8192;
		a1_1     <= 18'sd32768;
		b0_1     <= 18'sd16384;
		b1_1     <= 18'sd16384;
		wait_words(12, 200);

		// Phase 3, gains near +2 and -2 on full scale input
		@(posedge clk1);
		extreme <= 1'b1;
		a1_0    <= 18'sh1FFFF;
		b0_0    <= 18'sh1FFFF;
		b1_0    <= 18'sh1FFFF;
		a1_1    <= 18'sh20001;
		b0_1    <= 18'sh20001;
		b1_1    <= 18'sh20001;
		wait_words(12, 200);

		// Phase 4, random coefficients under back-pressure
		@(posedge clk1);
		extreme  <= 1'b0;
		stall_on <= 1'b1;
		a1_0     <= $random(seed);
		b0_0     <= $random(seed);
		b1_0     <= $random(seed);
		a1_1     <= $random(seed);
		b0_1     <= $random(seed);
		b1_1     <= $random(seed);
		wait_words(40, 1000);

		stall_on <= 1'b0;
		repeat (4) @(posedge clk1); // Let the last checks settle

		total = u_dut.u_checker.fail_count + timeouts;
		$display("Error counts: %0d assertion failures, %0d timeouts",
			u_dut.u_checker.fail_count, timeouts);
		if (total == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule
